//--- all.f
source/dl_pkg.sv
source/spi_byte_rx.sv
source/dl_fifo.sv
source/dl_packer.sv
source/sdram_wr_port.sv
source/dl_top.sv
sim/dl_tb_sva.sv
sim/dl_tb.sv

//--- Makefile
# Verilator flow for the ROM download path

VERILATOR ?= verilator
TOP       ?= dl_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_MSG  ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/dl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dl_tb;

    localparam int MAX_WORDS = 32;

    logic              clk;
    logic              rst;
    logic              spi_sck;
    logic              spi_ss;
    logic              spi_di;
    logic              mem_req;
    dl_pkg::mem_word_t mem_word;
    logic              mem_ack;
    logic              downloading;
    logic              dwnld_busy;

    logic [31:0]       stim_seed;
    logic [7:0]        byte_q[$];
    int                frame_len_q[$];
    int                dl_frames[2];
    int                exp_count[2];
    dl_pkg::mem_word_t model[2][MAX_WORDS];
    logic              written[MAX_WORDS];
    int                cur_dl;
    int                words_seen;
    int                words_total;
    int                errors;
    int                cycles;
    int                limit;
    logic              start_sent;
    logic              prev_dl;
    logic              prev_busy;

    dl_top UUT (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .spi_sck     ( spi_sck     ),
        .spi_ss      ( spi_ss      ),
        .spi_di      ( spi_di      ),
        .mem_req     ( mem_req     ),
        .mem_word    ( mem_word    ),
        .mem_ack     ( mem_ack     ),
        .downloading ( downloading ),
        .dwnld_busy  ( dwnld_busy  )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Value in 0 .. n-1 from the upper LCG bits
    function automatic int rand_below(input int n);
        stim_seed = lcg_next(stim_seed);
        return int'(stim_seed[30:16]) % n;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%0t: %s", $time, msg);
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t %s expected=%b actual=%b", $time, name, expected, actual);
        end
    endtask

    // Bytes masked by dqm are not compared
    task automatic check_word(input dl_pkg::mem_word_t expected,
                              input dl_pkg::mem_word_t actual);
        logic [15:0] keep;
        keep = {{8{~expected.dqm[1]}}, {8{~expected.dqm[0]}}};
        if (actual.addr !== expected.addr || actual.dqm !== expected.dqm ||
            (actual.data & keep) !== (expected.data & keep)) begin
            errors++;
            $display("ERR %0t mem_word expected addr=%h data=%h dqm=%b actual addr=%h data=%h dqm=%b",
                     $time, expected.addr, expected.data, expected.dqm,
                     actual.addr, actual.data, actual.dqm);
        end
    endtask

    // One download: START, 1 to 4 DATA frames, END, with the model words
    task automatic build_download(input int d, input logic odd);
        int         nf;
        int         total;
        int         len;
        int         w;
        logic [7:0] b;
        nf = 1 + rand_below(4);
        total = 0;
        byte_q.push_back(dl_pkg::DL_OP_START);
        frame_len_q.push_back(1);
        for (int f = 0; f < nf; f++) begin
            len = 1 + rand_below(12);
            if (f == nf - 1 && (((total + len) % 2) == 1) != odd) begin
                len = (len == 12) ? 11 : len + 1;
            end
            byte_q.push_back(dl_pkg::DL_OP_DATA);
            for (int i = 0; i < len; i++) begin
                b = 8'(rand_below(256));
                byte_q.push_back(b);
                w = (total + i) / 2;
                model[d][w].addr = w[dl_pkg::ADDR_W-1:0];
                if ((total + i) % 2 == 0) begin
                    // Low byte first, high half masked until its byte arrives
                    model[d][w].data = {8'h00, b};
                    model[d][w].dqm  = 2'b10;
                end else begin
                    model[d][w].data[15:8] = b;
                    model[d][w].dqm        = 2'b00;
                end
            end
            frame_len_q.push_back(len + 1);
            total += len;
        end
        byte_q.push_back(dl_pkg::DL_OP_END);
        frame_len_q.push_back(1);
        dl_frames[d] = nf + 2;
        exp_count[d] = (total + 1) / 2;
    endtask

    task automatic send_frame(input int first, input int len);
        int         half;
        logic [7:0] b;
        half = 4 + rand_below(4);
        spi_ss = 1'b0;
        wait_cycles(4);
        for (int i = 0; i < len; i++) begin
            b = byte_q[first + i];
            for (int k = 7; k >= 0; k--) begin
                spi_di  = b[k];
                spi_sck = 1'b0;
                wait_cycles(half);
                spi_sck = 1'b1;
                wait_cycles(half);
            end
        end
        spi_sck = 1'b0;
        wait_cycles(4);
        spi_ss = 1'b1;
        wait_cycles(6);
    endtask

    // Memory side of the four-phase handshake
    task automatic serve_write();
        dl_pkg::mem_word_t w;
        int                a;
        @(negedge clk);
        while (mem_req !== 1'b1) begin
            @(negedge clk);
        end
        w = mem_word;
        a = int'(w.addr);
        if (a >= exp_count[cur_dl]) begin
            report_failure($sformatf("write to word %0d beyond the download", a));
        end else if (written[a]) begin
            report_failure($sformatf("word %0d written twice", a));
        end else begin
            written[a] = 1'b1;
            check_word(model[cur_dl][a], w);
        end
        words_seen++;
        words_total++;
        wait_cycles(rand_below(7));
        mem_ack = 1'b1;
        while (mem_req === 1'b1) begin
            @(negedge clk);
        end
        wait_cycles(rand_below(7));
        mem_ack = 1'b0;
    endtask

    initial begin
        forever serve_write();
    end

    // Flag monitor, busy follows downloading up and outlasts it down
    always @(negedge clk) begin
        if (!rst && !start_sent) begin
            check_flag("mem_req", 1'b0, mem_req);
            check_flag("downloading", 1'b0, downloading);
            check_flag("dwnld_busy", 1'b0, dwnld_busy);
        end
        if (!rst && (downloading !== prev_dl)) begin
            check_flag("dwnld_busy", 1'b1, dwnld_busy);
        end
        if (!rst && prev_busy && !dwnld_busy) begin
            check_flag("downloading", 1'b0, downloading);
            check_flag("mem_req", 1'b0, mem_req);
            check_flag("mem_ack", 1'b0, mem_ack);
        end
        prev_dl   = downloading;
        prev_busy = dwnld_busy;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: the run did not end within %0d cycles", limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        int first;
        int fidx;
        rst         = 1'b1;
        spi_sck     = 1'b0;
        spi_ss      = 1'b1;
        spi_di      = 1'b0;
        mem_ack     = 1'b0;
        start_sent  = 1'b0;
        prev_dl     = 1'b0;
        prev_busy   = 1'b0;
        errors      = 0;
        cycles      = 0;
        words_seen  = 0;
        words_total = 0;
        cur_dl      = 0;
        stim_seed   = 32'hfc52;
        foreach (written[i]) written[i] = 1'b0;
        build_download(0, 1'b1);
        build_download(1, 1'b0);
        limit = byte_q.size() * 8 * 16 + (exp_count[0] + exp_count[1]) * 16 + 1000;
        wait_cycles(5);
        rst = 1'b0;
        // Quiet link after reset
        wait_cycles(20);
        first = 0;
        fidx  = 0;
        for (int d = 0; d < 2; d++) begin
            cur_dl     = d;
            words_seen = 0;
            foreach (written[i]) written[i] = 1'b0;
            start_sent = 1'b1;
            for (int f = 0; f < dl_frames[d]; f++) begin
                send_frame(first, frame_len_q[fidx]);
                first += frame_len_q[fidx];
                fidx++;
                if (f == 0) begin
                    @(negedge clk);
                    check_flag("downloading", 1'b1, downloading);
                    check_flag("dwnld_busy", 1'b1, dwnld_busy);
                end
            end
            while (dwnld_busy) begin
                @(negedge clk);
            end
            if (words_seen != exp_count[d]) begin
                report_failure($sformatf("download %0d wrote %0d words instead of %0d",
                                         d, words_seen, exp_count[d]));
            end
        end
        $display("Done: %0d words written, %0d errors", words_total, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/dl_tb_sva.sv
`timescale 1ns/1ps
`default_nettype none

module dl_tb_sva (
    input logic              clk,
    input logic              rst,
    input logic              mem_req,
    input logic              mem_ack,
    input dl_pkg::mem_word_t mem_word,
    input logic              overflow
);

    // Word frozen from the rise of req until ack has dropped
    property word_held;
        @(posedge clk) disable iff (rst)
            (mem_req || mem_ack) && $past(mem_req || mem_ack) |-> $stable(mem_word);
    endproperty

    // Four-phase rule, a new request waits for the old ack to fall
    property req_after_ack_low;
        @(posedge clk) disable iff (rst)
            $rose(mem_req) |-> !mem_ack;
    endproperty

    property no_overflow;
        @(posedge clk) disable iff (rst)
            !overflow;
    endproperty

    a_word_held: assert property (word_held)
        else $error("mem_word changed while a write request was pending");
    a_req_after_ack_low: assert property (req_after_ack_low)
        else $error("mem_req rose while mem_ack was still high");
    a_no_overflow: assert property (no_overflow)
        else $error("byte FIFO overflowed and an SPI byte was lost");

endmodule

bind dl_top dl_tb_sva u_sva (
    .clk      ( clk      ),
    .rst      ( rst      ),
    .mem_req  ( mem_req  ),
    .mem_ack  ( mem_ack  ),
    .mem_word ( mem_word ),
    .overflow ( overflow )
);

`default_nettype wire

//--- source/dl_top.sv
`timescale 1ns/1ps
`default_nettype none

module dl_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              spi_sck,
    input  logic              spi_ss,
    input  logic              spi_di,
    output logic              mem_req,
    output dl_pkg::mem_word_t mem_word,
    input  logic              mem_ack,
    output logic              downloading,
    output logic              dwnld_busy
);

    logic              rx_push;
    logic              overflow;
    dl_pkg::dl_byte_t  rx_byte;
    dl_pkg::dl_byte_t  byte_dout;
    logic              byte_full;
    logic              byte_empty;
    logic              pk_pop;
    logic              pk_push;
    logic              partial;
    dl_pkg::mem_word_t pk_word;
    dl_pkg::mem_word_t word_dout;
    logic              word_full;
    logic              word_empty;
    logic              wp_pop;
    logic              port_idle;
    logic              start_pop;
    logic              drained;

    spi_byte_rx u_rx (
        .clk      ( clk       ),
        .rst      ( rst       ),
        .spi_sck  ( spi_sck   ),
        .spi_ss   ( spi_ss    ),
        .spi_di   ( spi_di    ),
        .push     ( rx_push   ),
        .byte_out ( rx_byte   ),
        .full     ( byte_full ),
        .overflow ( overflow  )
    );

    dl_fifo #(.payload_t(dl_pkg::dl_byte_t)) u_byte_fifo (
        .clk   ( clk        ),
        .rst   ( rst        ),
        .push  ( rx_push    ),
        .din   ( rx_byte    ),
        .full  ( byte_full  ),
        .pop   ( pk_pop     ),
        .dout  ( byte_dout  ),
        .empty ( byte_empty )
    );

    dl_packer u_packer (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .pop         ( pk_pop      ),
        .byte_in     ( byte_dout   ),
        .empty       ( byte_empty  ),
        .push        ( pk_push     ),
        .word_out    ( pk_word     ),
        .full        ( word_full   ),
        .downloading ( downloading ),
        .partial     ( partial     )
    );

    dl_fifo #(.payload_t(dl_pkg::mem_word_t)) u_word_fifo (
        .clk   ( clk        ),
        .rst   ( rst        ),
        .push  ( pk_push    ),
        .din   ( pk_word    ),
        .full  ( word_full  ),
        .pop   ( wp_pop     ),
        .dout  ( word_dout  ),
        .empty ( word_empty )
    );

    sdram_wr_port u_wr_port (
        .clk      ( clk        ),
        .rst      ( rst        ),
        .pop      ( wp_pop     ),
        .word_in  ( word_dout  ),
        .empty    ( word_empty ),
        .mem_req  ( mem_req    ),
        .mem_word ( mem_word   ),
        .mem_ack  ( mem_ack    ),
        .idle     ( port_idle  )
    );

    // Same edge at which the packer raises downloading
    assign start_pop = pk_pop & byte_dout.is_op & (byte_dout.data == dl_pkg::DL_OP_START);

    // Nothing left anywhere between the SPI link and the memory
    assign drained = ~downloading & byte_empty & word_empty & ~partial & port_idle;

    always_ff @(posedge clk) begin
        if (rst) begin
            dwnld_busy <= 1'b0;
        end else if (start_pop) begin
            dwnld_busy <= 1'b1;
        end else if (drained) begin
            dwnld_busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/sdram_wr_port.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_wr_port (
    input  logic              clk,
    input  logic              rst,
    output logic              pop,
    input  dl_pkg::mem_word_t word_in,
    input  logic              empty,
    output logic              mem_req,
    output dl_pkg::mem_word_t mem_word,
    input  logic              mem_ack,
    output logic              idle
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_ACK_LOW
    } state_t;

    state_t            state;
    dl_pkg::mem_word_t word_q;

    // A new word is taken only once the previous ack has dropped
    assign pop      = (state == IDLE) & ~empty & ~mem_ack;
    assign mem_req  = (state == REQ);
    assign mem_word = word_q;
    assign idle     = (state == IDLE) & ~mem_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (pop) begin
                        state <= REQ;
                    end
                end
                REQ: begin
                    // Memory has written the word
                    if (mem_ack) begin
                        state <= WAIT_ACK_LOW;
                    end
                end
                WAIT_ACK_LOW: begin
                    if (!mem_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Held from the rise of req until ack falls
    always_ff @(posedge clk) begin
        if (pop) begin
            word_q <= word_in;
        end
    end

endmodule

`default_nettype wire

//--- source/dl_packer.sv
`timescale 1ns/1ps
`default_nettype none

module dl_packer (
    input  logic              clk,
    input  logic              rst,
    output logic              pop,
    input  dl_pkg::dl_byte_t  byte_in,
    input  logic              empty,
    output logic              push,
    output dl_pkg::mem_word_t word_out,
    input  logic              full,
    output logic              downloading,
    output logic              partial
);

    logic [dl_pkg::ADDR_W:0] byte_addr;
    logic                    data_en;
    logic                    have_lo;
    logic [7:0]              lo_byte;
    logic                    push_q;
    logic                    op_start;
    logic                    op_data;
    logic                    op_end;
    logic                    take_byte;
    logic                    take_hi;
    logic                    flush;

    assign pop = ~empty & ~full;

    assign op_start = pop & byte_in.is_op & (byte_in.data == dl_pkg::DL_OP_START);
    assign op_data  = pop & byte_in.is_op & (byte_in.data == dl_pkg::DL_OP_DATA);
    assign op_end   = pop & byte_in.is_op & (byte_in.data == dl_pkg::DL_OP_END);

    // Payload bytes only count inside an open DATA frame
    assign take_byte = pop & ~byte_in.is_op & ~byte_in.frame_end & data_en;
    assign take_hi   = take_byte & byte_addr[0];
    assign flush     = op_end & have_lo;

    assign push    = push_q;
    assign partial = have_lo | push_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            downloading <= 1'b0;
            data_en     <= 1'b0;
            have_lo     <= 1'b0;
            push_q      <= 1'b0;
            byte_addr   <= '0;
        end else begin
            // A word refused by a full FIFO stays pending
            push_q <= (push_q & full) | take_hi | flush;
            if (pop && byte_in.is_op) begin
                // Unknown opcodes close packing until the next DATA frame
                data_en <= op_data & downloading;
            end
            if (op_start) begin
                downloading <= 1'b1;
                byte_addr   <= '0;
                have_lo     <= 1'b0;
            end
            if (op_end) begin
                downloading <= 1'b0;
                have_lo     <= 1'b0;
            end
            if (take_byte) begin
                byte_addr <= byte_addr + 1'b1;
                have_lo   <= ~byte_addr[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_byte && !byte_addr[0]) begin
            lo_byte <= byte_in.data;
        end
        if (take_hi) begin
            word_out.addr <= byte_addr[dl_pkg::ADDR_W:1];
            word_out.data <= {byte_in.data, lo_byte};
            word_out.dqm  <= 2'b00;
        end else if (flush) begin
            // Odd byte count, high half of the last word is masked
            word_out.addr <= byte_addr[dl_pkg::ADDR_W:1];
            word_out.data <= {8'h00, lo_byte};
            word_out.dqm  <= 2'b10;
        end
    end

endmodule

`default_nettype wire

//--- source/dl_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module dl_fifo #(
    parameter type payload_t = dl_pkg::dl_byte_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t din,
    output logic     full,
    input  logic     pop,
    output payload_t dout,
    output logic     empty
);

    localparam int DEPTH = dl_pkg::FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;
    assign full    = (count == (PTR_W+1)'(DEPTH));
    assign empty   = (count == '0);

    // Head entry is always visible
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/spi_byte_rx.sv
`timescale 1ns/1ps
`default_nettype none

module spi_byte_rx (
    input  logic             clk,
    input  logic             rst,
    input  logic             spi_sck,
    input  logic             spi_ss,
    input  logic             spi_di,
    output logic             push,
    output dl_pkg::dl_byte_t byte_out,
    input  logic             full,
    output logic             overflow
);

    localparam int SN = dl_pkg::SCK_SYNC;

    logic [SN-1:0] sck_sr;
    logic [SN-1:0] ss_sr;
    logic [SN-1:0] di_sr;
    logic          sck_d;
    logic          ss_d;
    logic          sck_rise;
    logic          ss_fall;
    logic          ss_rise;
    logic          bit_vld;
    logic          bit_val;
    logic [2:0]    bit_cnt;
    logic [7:0]    shift;
    logic          byte_done;
    logic          first;
    logic          ss_rose;

    assign sck_rise = sck_sr[SN-1] & ~sck_d;
    assign ss_fall  = ~ss_sr[SN-1] & ss_d;
    assign ss_rise  = ss_sr[SN-1] & ~ss_d;

    // Oversampling of the SPI lines, SS idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            sck_sr <= '0;
            ss_sr  <= '1;
            di_sr  <= '0;
            sck_d  <= 1'b0;
            ss_d   <= 1'b1;
        end else begin
            sck_sr <= {sck_sr[SN-2:0], spi_sck};
            ss_sr  <= {ss_sr[SN-2:0], spi_ss};
            di_sr  <= {di_sr[SN-2:0], spi_di};
            sck_d  <= sck_sr[SN-1];
            ss_d   <= ss_sr[SN-1];
        end
    end

    // Bit counter, any SS edge throws away a partial byte
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_vld   <= 1'b0;
            bit_cnt   <= '0;
            byte_done <= 1'b0;
        end else begin
            bit_vld   <= sck_rise & ~ss_sr[SN-1];
            byte_done <= 1'b0;
            if (ss_rise || ss_fall) begin
                bit_cnt <= '0;
            end else if (bit_vld) begin
                bit_cnt   <= bit_cnt + 3'd1;
                byte_done <= (bit_cnt == 3'd7);
            end
        end
    end

    // MSB first
    always_ff @(posedge clk) begin
        if (sck_rise) begin
            bit_val <= di_sr[SN-1];
        end
        if (bit_vld) begin
            shift <= {shift[6:0], bit_val};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            push     <= 1'b0;
            overflow <= 1'b0;
            first    <= 1'b0;
            ss_rose  <= 1'b0;
        end else begin
            push <= 1'b0;
            if (byte_done) begin
                // No room in the byte FIFO: the byte is lost for good
                if (full) begin
                    overflow <= 1'b1;
                end else begin
                    push <= 1'b1;
                end
                first   <= 1'b0;
                ss_rose <= 1'b0;
            end
            if (ss_fall) begin
                first <= 1'b1;
            end
            if (ss_rise) begin
                ss_rose <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_done) begin
            byte_out.data      <= shift;
            byte_out.is_op     <= first;
            byte_out.frame_end <= ss_rose;
        end
    end

endmodule

`default_nettype wire

//--- source/dl_pkg.sv
`default_nettype none

package dl_pkg;

    // Frame opcodes sent by the I/O controller as the first byte after SS falls
    localparam logic [7:0] DL_OP_START = 8'h53;
    localparam logic [7:0] DL_OP_DATA  = 8'h54;
    localparam logic [7:0] DL_OP_END   = 8'h55;

    // SDRAM word address width
    localparam int ADDR_W = 22;

    // Entries in each FIFO
    localparam int FIFO_DEPTH = 8;

    // Synchronizer stages on SCK, SS and DI
    localparam int SCK_SYNC = 2;

    // One received SPI byte with its framing tags
    typedef struct packed {
        logic [7:0] data;
        // First byte of a frame
        logic       is_op;
        // SS rose since the previous byte
        logic       frame_end;
    } dl_byte_t;

    // One word write toward the SDRAM
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [15:0]       data;
        // Active high byte mask, bit 0 masks the low byte
        logic [1:0]        dqm;
    } mem_word_t;

endpackage

`default_nettype wire
